// File: Makefile
# Verilator build and run of the line memory testbench

SRCS := cl_cfg.svh $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_line_mem: tb.f $(SRCS)
	verilator --binary --timescale 1ns/1ns --top-module tb_line_mem \
		-f tb.f -Mdir obj_dir

# the log decides pass or fail
run: obj_dir/Vtb_line_mem
	./obj_dir/Vtb_line_mem | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: burst_if.sv
`timescale 1ns/1ns

interface burst_if;
    import line_pkg::*;
    import mem_pkg::*;

    addr_t  address;  // always line aligned
    logic   read;     // held for the whole line
    logic   write;    // held for the whole line
    burst_t wdata;    // current write beat
    burst_t rdata;    // valid while resp is high
    logic   resp;     // one pulse per beat

    // adaptor side
    modport ctrl (
        output address,
        output read,
        output write,
        output wdata,
        input  rdata,
        input  resp
    );

    // sram side
    modport mem (
        input  address,
        input  read,
        input  write,
        input  wdata,
        output rdata,
        output resp
    );

endinterface : burst_if

// File: burst_sram.sv
`timescale 1ns/1ns
`include "cl_cfg.svh"

module burst_sram
(
    input  logic clk,
    input  logic reset_n,
    burst_if.mem bus
);
    import line_pkg::*;
    import mem_pkg::*;

    localparam int WAIT_BITS = $clog2(`CL_MEM_WAIT + 2);  // wide enough for a zero wait
    localparam int WORDS     = `CL_MEM_LINES * BEATS;

    burst_t                   mem_q [0:WORDS-1];
    logic [WAIT_BITS-1:0]     wait_cnt;
    beat_t                    beat;       // beat being answered
    beat_t                    next_beat;
    logic                     active;
    logic                     line_done;
    logic                     fire;
    logic [LINE_IDX_BITS-1:0] line_idx;
    word_addr_t               wr_idx;
    word_addr_t               rd_idx;

    assign active = bus.read | bus.write;

    // bits 10:5 pick the line, the rest of the address is ignored
    assign line_idx = bus.address[LINE_OFFSET_BITS +: LINE_IDX_BITS];

    // resp on the last beat, nothing more until the request drops
    assign line_done = bus.resp && (beat == beat_t'(BEATS - 1));

    // a resp cycle already counts towards the next beat
    assign next_beat = bus.resp ? beat_t'(beat + 1'b1) : beat;
    assign fire      = active && !line_done && (wait_cnt == WAIT_BITS'(`CL_MEM_WAIT));

    assign wr_idx = {line_idx, beat};
    assign rd_idx = {line_idx, next_beat};  // beat after this edge

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wait_cnt <= '0;
            beat     <= '0;
            bus.resp <= 1'b0;
        end
        else if (!active)
        begin
            // request gone, drop whatever was in progress
            wait_cnt <= '0;
            beat     <= '0;
            bus.resp <= 1'b0;
        end
        else
        begin
            bus.resp <= fire;
            if (bus.resp)
                beat <= beat + 1'b1;
            if (fire || line_done)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        // write beat is stored at the edge that sees its resp
        if (bus.write && bus.resp)
            mem_q[wr_idx] <= bus.wdata;

        // read data lines up with resp
        if (bus.read && fire)
            bus.rdata <= mem_q[rd_idx];
    end

endmodule : burst_sram

// File: cacheline_adaptor.sv
`timescale 1ns/1ns

module cacheline_adaptor
(
    input  logic            clk,
    input  logic            reset_n,

    // cache side
    input  line_pkg::line_t line_i,
    output line_pkg::line_t line_o,
    input  line_pkg::addr_t address_i,
    input  logic            read_i,
    input  logic            write_i,
    output logic            resp_o,

    // burst side, towards the sram
    burst_if.ctrl           mem
);
    import line_pkg::*;
    import mem_pkg::*;

    localparam int WORD_BITS = $bits(burst_t);
    localparam int BUF_BITS  = $bits(line_t) - WORD_BITS;  // all beats but the last

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } state_t;

    state_t              state;
    beat_t               beat;       // beat in flight on the bus
    logic                read_q;
    logic                write_q;
    logic                rd_req;
    logic                wr_req;
    logic                last_beat;
    logic [BUF_BITS-1:0] rd_buf;     // beats collected so far

    // a request is the first cycle of a high level
    assign rd_req = read_i & ~read_q;
    assign wr_req = write_i & ~write_q;

    assign last_beat = (beat == beat_t'(BEATS - 1));

    // one pulse per line, the cycle after the last beat
    assign resp_o = (state == ST_DONE);

    // current slice of the line, moves on after each resp
    assign mem.wdata = line_i[beat * WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
        end
        else
        begin
            read_q  <= read_i;
            write_q <= write_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= ST_IDLE;
            beat      <= '0;
            mem.read  <= 1'b0;
            mem.write <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    beat <= '0;
                    if (rd_req)  // read wins over write
                    begin
                        mem.read <= 1'b1;
                        state    <= ST_READ;
                    end
                    else if (wr_req)
                    begin
                        mem.write <= 1'b1;
                        state     <= ST_WRITE;
                    end
                end

                ST_READ, ST_WRITE:
                begin
                    // strobes arriving here are dropped
                    if (mem.resp)
                    begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                        begin
                            mem.read  <= 1'b0;
                            mem.write <= 1'b0;
                            state     <= ST_DONE;
                        end
                    end
                end

                ST_DONE:
                    state <= ST_IDLE;  // resp_o high for this cycle only

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // line aligned address, held for the whole transfer
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && (rd_req || wr_req))
        begin
            mem.address <= {address_i[$bits(addr_t)-1:LINE_OFFSET_BITS],
                            {LINE_OFFSET_BITS{1'b0}}};
        end
    end

    // beats shift in from the top, so beat 0 ends up in the low bits.
    // line_o only changes once the whole line is here
    always_ff @(posedge clk)
    begin
        if (state == ST_READ && mem.resp)
        begin
            if (last_beat)
                line_o <= {mem.rdata, rd_buf};
            else
                rd_buf <= {mem.rdata, rd_buf[BUF_BITS-1:WORD_BITS]};
        end
    end

endmodule : cacheline_adaptor

// File: cl_cfg.svh
`ifndef CL_CFG_SVH
`define CL_CFG_SVH

// cache line width, one transfer on the cache side
`define CL_LINE_BITS   256

// memory word, one burst beat
`define CL_BURST_BITS  64

`define CL_ADDR_BITS   32  // byte address

// memory depth in lines, address wraps above this
`define CL_MEM_LINES   64

// idle cycles before each beat
`define CL_MEM_WAIT    2

`endif

// File: line_mem_top.sv
`timescale 1ns/1ns

module line_mem_top
(
    input  logic            clk,
    input  logic            reset_n,

    // cache side strobes
    input  logic            read_i,
    input  logic            write_i,

    input  line_pkg::addr_t address_i,
    input  line_pkg::line_t line_i,    // hold until resp_o
    output line_pkg::line_t line_o,
    output logic            resp_o
);

    // adaptor to sram burst link
    burst_if bus ();

    cacheline_adaptor i_cacheline_adaptor
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .line_i    (line_i),
        .line_o    (line_o),
        .address_i (address_i),
        .read_i    (read_i),
        .write_i   (write_i),
        .resp_o    (resp_o),
        .mem       (bus.ctrl)
    );

    // word wide memory behind the adaptor
    burst_sram i_burst_sram
    (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (bus.mem)
    );

endmodule : line_mem_top

// File: line_pkg.sv
`include "cl_cfg.svh"

// cache side view of a transfer
package line_pkg;

    // byte offset bits inside one line
    localparam int LINE_OFFSET_BITS = $clog2(`CL_LINE_BITS / 8);

    // one full cache line
    typedef logic [`CL_LINE_BITS-1:0] line_t;

    typedef logic [`CL_ADDR_BITS-1:0] addr_t;  // byte address

endpackage : line_pkg

// File: mem_pkg.sv
`include "cl_cfg.svh"

// memory side view, words and beats
package mem_pkg;

    // beats needed to move one line
    localparam int BEATS          = `CL_LINE_BITS / `CL_BURST_BITS;
    localparam int BEAT_BITS      = $clog2(BEATS);

    localparam int LINE_IDX_BITS  = $clog2(`CL_MEM_LINES);  // line index in the sram
    localparam int WORD_ADDR_BITS = LINE_IDX_BITS + BEAT_BITS;

    typedef logic [`CL_BURST_BITS-1:0] burst_t;  // one memory word

    // word index, line index on top of beat
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

    typedef logic [BEAT_BITS-1:0] beat_t;

endpackage : mem_pkg

// File: tb.f
+incdir+.
line_pkg.sv
mem_pkg.sv
burst_if.sv
cacheline_adaptor.sv
burst_sram.sv
line_mem_top.sv
tb_clock_gen.sv
tb_line_mem.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
)
(
    output logic clk_o,
    output logic reset_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset drops just after an edge, same as the other inputs
    initial
    begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_n_o = 1'b1;
    end

endmodule : tb_clock_gen

// File: tb_line_mem.sv
`timescale 1ns/1ns
`include "cl_cfg.svh"

module tb_line_mem;
    import line_pkg::*;

    localparam int BEAT_CYCLES     = `CL_MEM_WAIT + 1;
    localparam int LINE_CYCLES     = 4 * BEAT_CYCLES + 4;  // one transfer
    localparam int N_TRANSFERS     = 40;
    localparam int RESP_LIMIT      = 2 * LINE_CYCLES;
    localparam int WATCHDOG_CYCLES = N_TRANSFERS * LINE_CYCLES + 200;
    localparam int N_LINES         = `CL_MEM_LINES;

    logic        clk;
    logic        reset_n;
    logic        read_i;
    logic        write_i;
    logic        resp_o;
    addr_t       address_i;
    line_t       line_i;
    line_t       line_o;

    line_t       shadow [0:N_LINES-1];  // expected memory contents per line
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(8)) i_tb_clock_gen
    (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    line_mem_top i_line_mem_top
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .read_i    (read_i),
        .write_i   (write_i),
        .address_i (address_i),
        .line_i    (line_i),
        .line_o    (line_o),
        .resp_o    (resp_o)
    );

    task automatic check_line(input line_t got, input line_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("error at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    // bits 10:5 select the line
    function automatic int line_index(input addr_t addr);
        return int'(addr[10:5]);
    endfunction

    function automatic addr_t line_addr(input int idx);
        return addr_t'(idx) << 5;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < `CL_LINE_BITS / 32; i++)
            l[i*32 +: 32] = $urandom;
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_resp();
        int cycles;
        cycles = 0;
        while (resp_o !== 1'b1 && cycles < RESP_LIMIT)
        begin
            next_cycle();
            cycles++;
        end
        if (resp_o !== 1'b1)
        begin
            errors++;
            $display("no response from the DUT within %0d cycles at %0t ns", RESP_LIMIT, $time);
        end
    endtask

    task automatic write_line(input addr_t addr, input line_t data);
        address_i = addr;
        line_i    = data;
        write_i   = 1'b1;
        next_cycle();
        write_i   = 1'b0;
        wait_resp();
        next_cycle();
        check_bit(resp_o, 1'b0, "resp_o longer than one cycle after write");
    endtask

    task automatic read_line(input addr_t addr, output line_t data);
        address_i = addr;
        read_i    = 1'b1;
        next_cycle();
        read_i    = 1'b0;
        wait_resp();
        data = line_o;  // valid in the resp cycle
        next_cycle();
        check_bit(resp_o, 1'b0, "resp_o longer than one cycle after read");
    endtask

    task automatic idle_after_reset();
        repeat (16)
        begin
            check_bit(resp_o, 1'b0, "resp_o high while idle after reset");
            next_cycle();
        end
    endtask

    task automatic single_line_round_trip();
        addr_t addr;
        line_t data;
        line_t got;
        addr = line_addr($urandom_range(0, N_LINES - 1));
        data = random_line();
        write_line(addr, data);
        shadow[line_index(addr)] = data;
        read_line(addr, got);
        check_line(got, data, "single line read back");
    endtask

    task automatic many_lines_shuffled();
        int    idx [8];
        bit    used [0:N_LINES-1];
        int    cand;
        int    k;
        line_t got;
        for (int i = 0; i < 8; i++)
        begin
            do
                cand = $urandom_range(0, N_LINES - 1);
            while (used[cand]);
            used[cand] = 1'b1;
            idx[i] = cand;
            shadow[cand] = random_line();
            write_line(line_addr(cand), shadow[cand]);
        end
        // stride 3 visits all eight in another order
        for (int i = 0; i < 8; i++)
        begin
            k = (i * 3) % 8;
            read_line(line_addr(idx[k]), got);
            check_line(got, shadow[line_index(line_addr(idx[k]))],
                       $sformatf("line %0d after eight writes", idx[k]));
        end
    endtask

    task automatic overwrite_with_neighbour();
        int    a;
        int    n;
        line_t got;
        a = $urandom_range(0, N_LINES - 2);
        n = a + 1;
        shadow[n] = random_line();
        write_line(line_addr(n), shadow[n]);
        write_line(line_addr(a), random_line());
        shadow[a] = random_line();
        write_line(line_addr(a), shadow[a]);
        read_line(line_addr(a), got);
        check_line(got, shadow[a], "overwritten line");
        read_line(line_addr(n), got);
        check_line(got, shadow[n], "neighbour of overwritten line");
    endtask

    task automatic address_aliases();
        int    idx;
        addr_t base;
        addr_t alias_hi;
        line_t got;
        idx  = $urandom_range(0, N_LINES - 1);
        base = line_addr(idx);
        shadow[idx] = random_line();
        write_line(base, shadow[idx]);
        read_line(base | addr_t'(32'h1f), got);
        check_line(got, shadow[idx], "alias in bits 4:0");
        alias_hi = (addr_t'($urandom) & ~addr_t'(32'h7ff)) | addr_t'(32'h8000_0000) | base;
        read_line(alias_hi, got);
        check_line(got, shadow[idx], "alias above bit 10");
        shadow[idx] = random_line();
        write_line(alias_hi | addr_t'($urandom_range(0, 31)), shadow[idx]);
        read_line(base, got);
        check_line(got, shadow[idx], "write through alias, read at base");
    endtask

    task automatic strobe_while_busy();
        int    p;
        int    q;
        int    resp_count;
        line_t got;
        p = $urandom_range(0, N_LINES - 1);
        q = (p + 17) % N_LINES;
        shadow[q] = random_line();
        write_line(line_addr(q), shadow[q]);

        shadow[p] = random_line();
        address_i = line_addr(p);
        line_i    = shadow[p];
        write_i   = 1'b1;
        next_cycle();
        write_i   = 1'b0;
        next_cycle();
        address_i = line_addr(q);  // second write lands mid transfer
        write_i   = 1'b1;
        next_cycle();
        write_i   = 1'b0;
        address_i = line_addr(p);
        resp_count = 0;
        repeat (2 * LINE_CYCLES)
        begin
            if (resp_o === 1'b1)
                resp_count++;
            next_cycle();
        end
        compare_count(resp_count, 1, "resp_o pulses with a strobe during a transfer");

        read_line(line_addr(p), got);
        check_line(got, shadow[p], "first request stored");
        read_line(line_addr(q), got);
        check_line(got, shadow[q], "ignored request left its line alone");
    endtask

    initial
    begin
        read_i    = 1'b0;
        write_i   = 1'b0;
        address_i = '0;
        line_i    = '0;
        void'($urandom(63572));

        wait (reset_n === 1'b1);
        next_cycle();

        idle_after_reset();
        single_line_round_trip();
        many_lines_shuffled();
        overwrite_with_neighbour();
        address_aliases();
        strobe_while_busy();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // ends a run that stalls
    initial
    begin
        repeat (WATCHDOG_CYCLES + 8) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_line_mem
